//--- rv_decoder.f
rtl/rv_decode_pkg.sv
rtl/decode_bus_if.sv
rtl/instr_capture.sv
rtl/imm_gen.sv
rtl/op_decoder.sv
rtl/ctrl_register.sv
rtl/rv_decoder_top.sv
tb/tb_rv_decoder.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       := tb_rv_decoder
FILELIST  := rv_decoder.f
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the binary exits non-zero on $fatal
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_rv_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv_decoder import rv_decode_pkg::*; ();

    typedef enum int {
        k_op, k_op_imm, k_load, k_store, k_branch, k_jal, k_jalr, k_lui, k_auipc
    } kind_t;

    typedef enum int {
        chk_bubble, chk_full, chk_illegal
    } chk_t;

    localparam int stream_len = 40;
    // drive cycles of all tests plus one bubble per stream entry
    localparam int budget_cycles = 13 + 19 + 16 + 18 + 7 + 18 + 2 * stream_len + 4;

    logic            clk;
    logic            rst_n;
    logic            instr_valid;
    logic [xlen-1:0] instruction;
    logic            ctrl_valid;
    alu_op_t         alu_op;
    logic            a_is_pc;
    logic            b_is_imm;
    logic [xlen-1:0] imm;
    reg_addr_t       rs1;
    logic            rs1_read;
    reg_addr_t       rs2;
    logic            rs2_read;
    reg_addr_t       rd;
    logic            rd_write;
    wb_sel_t         wb_sel;
    logic            mem_read;
    logic            mem_write;
    mem_width_t      mem_width;
    logic            mem_unsigned;
    branch_op_t      branch_op;
    logic            is_jump;
    logic            is_system;
    logic            illegal;

    logic [15:0]     lfsr = 16'd71;
    logic [31:0]     cur_w;
    ctrl_t           cur_e;
    logic [31:0]     cur_imm;
    chk_t            kind_q [$];
    ctrl_t           exp_ctrl_q [$];
    logic [31:0]     exp_imm_q [$];

    alu_op_t    alu_of_f3 [8]    = '{add, sll, slt, sltu, xor_op, srl, or_op, and_op};
    branch_op_t branch_of_f3 [8] = '{beq, bne, none, none, blt, bge, bltu, bgeu};

    rv_decoder_top u_rv_decoder_top (.*);

    always #5 clk = ~clk;

    // galois lfsr stepped once per bit
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int b = 0; b < n; b++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [31:0] sext(input logic [31:0] v, input int bits);
        logic signed [31:0] t;
        t = v << (32 - bits);
        return t >>> (32 - bits);
    endfunction

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        assert (got === want)
            else begin
                $display("FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
                         $time, name, got, want);
                $display("ERRORS FOUND");
                $fatal(1, "stopping at first mismatch");
            end
    endtask

    task automatic compare_enables(input ctrl_t e);
        expect_value("rs1_read", 32'(rs1_read), 32'(e.rs1_read));
        expect_value("rs2_read", 32'(rs2_read), 32'(e.rs2_read));
        expect_value("rd_write", 32'(rd_write), 32'(e.rd_write));
        expect_value("mem_read", 32'(mem_read), 32'(e.mem_read));
        expect_value("mem_write", 32'(mem_write), 32'(e.mem_write));
        expect_value("branch_op", 32'(branch_op), 32'(e.branch_op));
        expect_value("is_jump", 32'(is_jump), 32'(e.is_jump));
        expect_value("is_system", 32'(is_system), 32'(e.is_system));
        expect_value("illegal", 32'(illegal), 32'(e.illegal));
    endtask

    task automatic compare_bundle(input ctrl_t e);
        compare_enables(e);
        expect_value("alu_op", 32'(alu_op), 32'(e.alu_op));
        expect_value("a_is_pc", 32'(a_is_pc), 32'(e.a_is_pc));
        expect_value("b_is_imm", 32'(b_is_imm), 32'(e.b_is_imm));
        expect_value("rs1", 32'(rs1), 32'(e.rs1));
        expect_value("rs2", 32'(rs2), 32'(e.rs2));
        expect_value("rd", 32'(rd), 32'(e.rd));
        expect_value("wb_sel", 32'(wb_sel), 32'(e.wb_sel));
        expect_value("mem_width", 32'(mem_width), 32'(e.mem_width));
        expect_value("mem_unsigned", 32'(mem_unsigned), 32'(e.mem_unsigned));
    endtask

    // a result shows two edges after its drive edge
    always @(negedge clk) begin : scoreboard
        chk_t        k;
        ctrl_t       e;
        logic [31:0] i;
        if (kind_q.size() >= 3) begin
            k = kind_q.pop_front();
            e = exp_ctrl_q.pop_front();
            i = exp_imm_q.pop_front();
            expect_value("ctrl_valid", 32'(ctrl_valid), 32'(k != chk_bubble));
            if (k == chk_bubble) begin
                e = '0;
            end
            if (k == chk_illegal) begin
                compare_enables(e);
            end else begin
                compare_bundle(e);
            end
            if (k == chk_full) begin
                expect_value("imm", imm, i);
            end
        end
    end

    task automatic drive(input logic v, input logic [31:0] w, input chk_t k);
        @(posedge clk);
        instr_valid <= v;
        instruction <= w;
        kind_q.push_back(k);
        exp_ctrl_q.push_back(cur_e);
        exp_imm_q.push_back(cur_imm);
    endtask

    task automatic bubble();
        drive(1'b0, 32'h0, chk_bubble);
    endtask

    task automatic send_built();
        cur_e.rs1 = cur_w[19:15];  // register fields pass through for every format
        cur_e.rs2 = cur_w[24:20];
        cur_e.rd  = cur_w[11:7];
        drive(1'b1, cur_w, chk_full);
    endtask

    task automatic send_illegal(input logic [31:0] w);
        cur_e         = '0;
        cur_e.illegal = 1'b1;
        drive(1'b1, w, chk_illegal);
    endtask

    // encodes one instruction from random fields and sets its expected result
    task automatic build(input kind_t k, input logic [2:0] f3, input logic alt);
        logic [4:0]  dst;
        logic [4:0]  src1;
        logic [4:0]  src2;
        logic [11:0] imm12;
        logic [19:0] imm20;
        logic [12:0] imm13;
        logic [20:0] imm21;
        logic        alt_r;
        dst   = 5'(next_bits(5));
        src1  = 5'(next_bits(5));
        src2  = 5'(next_bits(5));
        imm12 = 12'(next_bits(12));
        imm20 = 20'(next_bits(20));
        imm13 = {imm12, 1'b0};
        imm21 = {imm20, 1'b0};
        cur_e = '0;
        case (k)
            k_op: begin
                alt_r          = alt && (f3 == 3'b000 || f3 == 3'b101);
                cur_w          = {alt_r ? 7'h20 : 7'h00, src2, src1, f3, dst, op};
                cur_imm        = '0;
                cur_e.alu_op   = alt_r ? (f3 == 3'b000 ? sub : sra) : alu_of_f3[f3];
                cur_e.rs1_read = 1'b1;
                cur_e.rs2_read = 1'b1;
                cur_e.rd_write = 1'b1;
            end
            k_op_imm: begin
                alt_r = alt && f3 == 3'b101;
                if (f3[1:0] == 2'b01) begin
                    imm12   = {1'b0, alt_r, 5'b0, src2};  // funct7 and shamt
                    cur_imm = 32'(src2);
                end else begin
                    cur_imm = sext(32'(imm12), 12);
                end
                cur_w          = {imm12, src1, f3, dst, op_imm};
                cur_e.alu_op   = alt_r ? sra : alu_of_f3[f3];
                cur_e.rs1_read = 1'b1;
                cur_e.b_is_imm = 1'b1;
                cur_e.rd_write = 1'b1;
            end
            k_load: begin
                cur_w              = {imm12, src1, f3, dst, load};
                cur_imm            = sext(32'(imm12), 12);
                cur_e.rs1_read     = 1'b1;
                cur_e.b_is_imm     = 1'b1;
                cur_e.rd_write     = 1'b1;
                cur_e.wb_sel       = mem;
                cur_e.mem_read     = 1'b1;
                cur_e.mem_width    = f3[1:0] == 2'b00 ? width_byte :
                                     f3[1:0] == 2'b01 ? width_half : width_word;
                cur_e.mem_unsigned = f3[2];
            end
            k_store: begin
                cur_w           = {imm12[11:5], src2, src1, f3, imm12[4:0], store};
                cur_imm         = sext(32'(imm12), 12);
                cur_e.rs1_read  = 1'b1;
                cur_e.rs2_read  = 1'b1;
                cur_e.b_is_imm  = 1'b1;
                cur_e.mem_write = 1'b1;
                cur_e.mem_width = f3[1:0] == 2'b00 ? width_byte :
                                  f3[1:0] == 2'b01 ? width_half : width_word;
            end
            k_branch: begin
                cur_w = {imm13[12], imm13[10:5], src2, src1, f3, imm13[4:1], imm13[11],
                         branch};
                cur_imm         = sext(32'(imm13), 13);
                cur_e.a_is_pc   = 1'b1;
                cur_e.b_is_imm  = 1'b1;
                cur_e.rs1_read  = 1'b1;
                cur_e.rs2_read  = 1'b1;
                cur_e.branch_op = branch_of_f3[f3];
            end
            k_jal: begin
                cur_w          = {imm21[20], imm21[10:1], imm21[11], imm21[19:12], dst, jal};
                cur_imm        = sext(32'(imm21), 21);
                cur_e.a_is_pc  = 1'b1;
                cur_e.b_is_imm = 1'b1;
                cur_e.rd_write = 1'b1;
                cur_e.wb_sel   = pc4;
                cur_e.is_jump  = 1'b1;
            end
            k_jalr: begin
                cur_w          = {imm12, src1, 3'b000, dst, jalr};
                cur_imm        = sext(32'(imm12), 12);
                cur_e.rs1_read = 1'b1;
                cur_e.b_is_imm = 1'b1;
                cur_e.rd_write = 1'b1;
                cur_e.wb_sel   = pc4;
                cur_e.is_jump  = 1'b1;
            end
            k_lui: begin
                cur_w          = {imm20, dst, lui};
                cur_imm        = {imm20, 12'h000};
                cur_e.alu_op   = pass_b;
                cur_e.b_is_imm = 1'b1;
                cur_e.rd_write = 1'b1;
            end
            k_auipc: begin
                cur_w          = {imm20, dst, auipc};
                cur_imm        = {imm20, 12'h000};
                cur_e.a_is_pc  = 1'b1;
                cur_e.b_is_imm = 1'b1;
                cur_e.rd_write = 1'b1;
            end
            default: begin
                cur_w   = '0;
                cur_imm = '0;
            end
        endcase
    endtask

    task automatic issue(input kind_t k, input logic [2:0] f3, input logic alt);
        build(k, f3, alt);
        send_built();
    endtask

    task automatic reset_and_bubbles();
        repeat (4) begin
            @(negedge clk);
            expect_value("ctrl_valid", 32'(ctrl_valid), 32'h0);
            compare_enables('0);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        bubble();
        bubble();
        issue(k_op, 3'b000, 1'b0);
        bubble();
        issue(k_lui, 3'b000, 1'b0);
        bubble();
    endtask

    task automatic alu_ops();
        for (int f3 = 0; f3 < 8; f3++) begin
            issue(k_op, 3'(f3), 1'b0);
            issue(k_op_imm, 3'(f3), 1'b0);
        end
        issue(k_op, 3'b000, 1'b1);
        issue(k_op, 3'b101, 1'b1);
        issue(k_op_imm, 3'b101, 1'b1);  // srai
    endtask

    task automatic loads_stores();
        for (int f3 = 0; f3 < 6; f3++) begin
            if (f3 != 3) begin
                issue(k_load, 3'(f3), 1'b0);
                issue(k_load, 3'(f3), 1'b0);
            end
        end
        for (int f3 = 0; f3 < 3; f3++) begin
            issue(k_store, 3'(f3), 1'b0);
            issue(k_store, 3'(f3), 1'b0);
        end
    endtask

    task automatic branches_jumps();
        for (int f3 = 0; f3 < 8; f3++) begin
            if (f3 != 2 && f3 != 3) begin
                issue(k_branch, 3'(f3), 1'b0);
                issue(k_branch, 3'(f3), 1'b0);
            end
        end
        repeat (3) issue(k_jal, 3'b000, 1'b0);
        repeat (3) issue(k_jalr, 3'b000, 1'b0);
    endtask

    task automatic upper_and_system();
        repeat (2) issue(k_lui, 3'b000, 1'b0);
        repeat (2) issue(k_auipc, 3'b000, 1'b0);
        cur_w   = 32'h0ff0_000f;  // fence iorw, iorw
        cur_e   = '0;
        cur_imm = '0;
        send_built();
        cur_w           = 32'h0000_0073;  // ecall
        cur_e.is_system = 1'b1;
        send_built();
        cur_w = 32'h0010_0073;  // ebreak
        send_built();
    endtask

    task automatic illegal_words();
        logic [31:0] bad [$];
        bad.push_back(32'h0000_0000);
        bad.push_back(32'hffff_ffff);
        bad.push_back({12'h123, 5'd1, 3'b011, 5'd2, load});  // ld is rv64 only
        bad.push_back({12'h004, 5'd1, 3'b110, 5'd2, load});
        bad.push_back({12'h004, 5'd1, 3'b111, 5'd2, load});
        bad.push_back({7'h00, 5'd3, 5'd1, 3'b011, 5'd0, store});
        bad.push_back({7'h00, 5'd3, 5'd1, 3'b100, 5'd0, store});
        bad.push_back({7'h00, 5'd3, 5'd1, 3'b010, 5'd0, branch});
        bad.push_back({7'h00, 5'd3, 5'd1, 3'b011, 5'd0, branch});
        bad.push_back({7'h01, 5'd3, 5'd1, 3'b000, 5'd4, op});  // mul
        bad.push_back({7'h20, 5'd3, 5'd1, 3'b001, 5'd4, op});
        bad.push_back({7'h20, 5'd3, 5'd1, 3'b111, 5'd4, op});
        bad.push_back({7'h20, 5'd3, 5'd1, 3'b001, 5'd4, op_imm});
        bad.push_back({7'h10, 5'd3, 5'd1, 3'b101, 5'd4, op_imm});
        bad.push_back({12'h000, 5'd1, 3'b001, 5'd4, jalr});
        bad.push_back(32'h1050_0073);  // wfi
        bad.push_back(32'h3000_1073);  // csrrw
        bad.push_back(32'h0000_00f3);  // ecall with rd set
        foreach (bad[n]) begin
            send_illegal(bad[n]);
        end
    endtask

    task automatic pipelined_stream();
        kind_t      kind;
        logic [2:0] f3;
        repeat (stream_len) begin
            if (next_bits(2) == 0) begin
                bubble();
            end
            kind = kind_t'(next_bits(4) % 9);
            f3   = 3'(next_bits(3));
            if (kind == k_load && (f3 == 3'b011 || f3[2:1] == 2'b11)) begin
                f3 = f3 & 3'b101;
            end
            if (kind == k_store) begin
                f3 = f3 % 3'd3;
            end
            if (kind == k_branch && f3[2:1] == 2'b01) begin
                f3[2] = 1'b1;
            end
            issue(kind, f3, 1'(next_bits(1)));
        end
    endtask

    initial begin
        #(2 * budget_cycles * 10);
        $display("timeout: tests did not finish within %0d cycles", 2 * budget_cycles);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instruction = '0;
        cur_w       = '0;
        cur_e       = '0;
        cur_imm     = '0;
        reset_and_bubbles();
        alu_ops();
        loads_stores();
        branches_jumps();
        upper_and_system();
        illegal_words();
        pipelined_stream();
        repeat (3) bubble();  // drain the two stages
        @(posedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/rv_decoder_top.sv
`timescale 1ns/1ns
`default_nettype none

module rv_decoder_top import rv_decode_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_valid,
    input  logic [xlen-1:0] instruction,
    output logic            ctrl_valid,
    output alu_op_t         alu_op,
    output logic            a_is_pc,
    output logic            b_is_imm,
    output logic [xlen-1:0] imm,
    output reg_addr_t       rs1,
    output logic            rs1_read,
    output reg_addr_t       rs2,
    output logic            rs2_read,
    output reg_addr_t       rd,
    output logic            rd_write,
    output wb_sel_t         wb_sel,
    output logic            mem_read,
    output logic            mem_write,
    output mem_width_t      mem_width,
    output logic            mem_unsigned,
    output branch_op_t      branch_op,
    output logic            is_jump,
    output logic            is_system,
    output logic            illegal
);

    decode_bus_if bus ();

    ctrl_t           ctrl;
    ctrl_t           ctrl_q;
    logic [xlen-1:0] imm_next;

    instr_capture u_instr_capture (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instruction (instruction),
        .bus         (bus.capture)
    );

    imm_gen u_imm_gen (
        .bus (bus.decode),
        .imm (imm_next)
    );

    op_decoder u_op_decoder (
        .bus  (bus.decode),
        .ctrl (ctrl)
    );

    ctrl_register u_ctrl_register (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus        (bus.decode),
        .ctrl       (ctrl),
        .imm        (imm_next),
        .ctrl_valid (ctrl_valid),
        .ctrl_q     (ctrl_q),
        .imm_q      (imm)
    );

    assign alu_op       = ctrl_q.alu_op;
    assign a_is_pc      = ctrl_q.a_is_pc;
    assign b_is_imm     = ctrl_q.b_is_imm;
    assign rs1          = ctrl_q.rs1;
    assign rs1_read     = ctrl_q.rs1_read;
    assign rs2          = ctrl_q.rs2;
    assign rs2_read     = ctrl_q.rs2_read;
    assign rd           = ctrl_q.rd;
    assign rd_write     = ctrl_q.rd_write;
    assign wb_sel       = ctrl_q.wb_sel;
    assign mem_read     = ctrl_q.mem_read;
    assign mem_write    = ctrl_q.mem_write;
    assign mem_width    = ctrl_q.mem_width;
    assign mem_unsigned = ctrl_q.mem_unsigned;
    assign branch_op    = ctrl_q.branch_op;
    assign is_jump      = ctrl_q.is_jump;
    assign is_system    = ctrl_q.is_system;
    assign illegal      = ctrl_q.illegal;

endmodule

`default_nettype wire

//--- rtl/ctrl_register.sv
`timescale 1ns/1ns
`default_nettype none

module ctrl_register import rv_decode_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    decode_bus_if.decode    bus,
    input  ctrl_t           ctrl,
    input  logic [xlen-1:0] imm,
    output logic            ctrl_valid,
    output ctrl_t           ctrl_q,
    output logic [xlen-1:0] imm_q
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_valid <= 1'b0;
            ctrl_q     <= '0;
        end else begin
            ctrl_valid <= bus.valid;
            if (bus.valid) begin
                ctrl_q <= ctrl;
            end else begin
                ctrl_q <= '0;  // bubble
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.valid) begin
            imm_q <= imm;
        end
    end

    // a held word must decode to known values
    assert property (@(posedge clk) disable iff (!rst_n)
        bus.valid |-> !$isunknown({ctrl, imm}))
        else $error("unknown bits in the decoded bundle");

endmodule

`default_nettype wire

//--- rtl/op_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module op_decoder import rv_decode_pkg::*; (
    decode_bus_if.decode bus,
    output ctrl_t        ctrl
);

    // caller qualifies alt for sub or sra
    function automatic alu_op_t alu_from_funct3(input logic [2:0] f3, input logic alt);
        alu_op_t res;
        case (f3)
            3'b000:  res = alt ? sub : add;
            3'b001:  res = sll;
            3'b010:  res = slt;
            3'b011:  res = sltu;
            3'b100:  res = xor_op;
            3'b101:  res = alt ? sra : srl;
            3'b110:  res = or_op;
            default: res = and_op;
        endcase
        return res;
    endfunction

    always_comb begin
        ctrl     = '0;
        ctrl.rs1 = bus.rs1;
        ctrl.rs2 = bus.rs2;
        ctrl.rd  = bus.rd;

        case (bus.opcode)
            lui: begin
                ctrl.alu_op   = pass_b;
                ctrl.b_is_imm = 1'b1;
                ctrl.rd_write = 1'b1;
            end
            auipc: begin
                ctrl.a_is_pc  = 1'b1;
                ctrl.b_is_imm = 1'b1;
                ctrl.rd_write = 1'b1;
            end
            jal: begin
                ctrl.a_is_pc  = 1'b1;
                ctrl.b_is_imm = 1'b1;
                ctrl.rd_write = 1'b1;
                ctrl.wb_sel   = pc4;
                ctrl.is_jump  = 1'b1;
            end
            jalr: begin
                ctrl.rs1_read = 1'b1;
                ctrl.b_is_imm = 1'b1;
                ctrl.rd_write = 1'b1;
                ctrl.wb_sel   = pc4;
                ctrl.is_jump  = 1'b1;
                ctrl.illegal  = bus.funct3 != 3'b000;
            end
            branch: begin
                ctrl.a_is_pc  = 1'b1;  // alu forms the target
                ctrl.b_is_imm = 1'b1;
                ctrl.rs1_read = 1'b1;
                ctrl.rs2_read = 1'b1;
                case (bus.funct3)
                    3'b000:  ctrl.branch_op = beq;
                    3'b001:  ctrl.branch_op = bne;
                    3'b100:  ctrl.branch_op = blt;
                    3'b101:  ctrl.branch_op = bge;
                    3'b110:  ctrl.branch_op = bltu;
                    3'b111:  ctrl.branch_op = bgeu;
                    default: ctrl.illegal   = 1'b1;
                endcase
            end
            load: begin
                ctrl.rs1_read     = 1'b1;
                ctrl.b_is_imm     = 1'b1;
                ctrl.rd_write     = 1'b1;
                ctrl.wb_sel       = mem;
                ctrl.mem_read     = 1'b1;
                ctrl.mem_width    = mem_width_t'(bus.funct3[1:0]);
                ctrl.mem_unsigned = bus.funct3[2];
                ctrl.illegal      = bus.funct3[1:0] == 2'b11 || bus.funct3[2:1] == 2'b11;
            end
            store: begin
                ctrl.rs1_read  = 1'b1;
                ctrl.rs2_read  = 1'b1;
                ctrl.b_is_imm  = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.mem_width = mem_width_t'(bus.funct3[1:0]);
                ctrl.illegal   = bus.funct3[2] || bus.funct3[1:0] == 2'b11;
            end
            op_imm: begin
                ctrl.rs1_read = 1'b1;
                ctrl.b_is_imm = 1'b1;
                ctrl.rd_write = 1'b1;
                // funct7 is immediate bits except on shifts
                ctrl.alu_op = alu_from_funct3(bus.funct3,
                                              bus.funct3 == 3'b101 && bus.funct7[5]);
                if (bus.funct3 == 3'b001) begin
                    ctrl.illegal = bus.funct7 != 7'h00;
                end else if (bus.funct3 == 3'b101) begin
                    ctrl.illegal = bus.funct7 != 7'h00 && bus.funct7 != 7'h20;
                end
            end
            op: begin
                ctrl.rs1_read = 1'b1;
                ctrl.rs2_read = 1'b1;
                ctrl.rd_write = 1'b1;
                ctrl.alu_op   = alu_from_funct3(bus.funct3, bus.funct7[5]);
                if (bus.funct7 == 7'h20) begin
                    ctrl.illegal = bus.funct3 != 3'b000 && bus.funct3 != 3'b101;
                end else begin
                    ctrl.illegal = bus.funct7 != 7'h00;
                end
            end
            misc_mem: begin
                ctrl.illegal = 1'b0;  // fence has nothing to order here
            end
            system: begin
                ctrl.is_system = 1'b1;
                ctrl.illegal   = bus.instruction != ecall_word &&
                                 bus.instruction != ebreak_word;
            end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase

        if (ctrl.illegal) begin
            ctrl.rs1_read  = 1'b0;
            ctrl.rs2_read  = 1'b0;
            ctrl.rd_write  = 1'b0;
            ctrl.mem_read  = 1'b0;
            ctrl.mem_write = 1'b0;
            ctrl.branch_op = none;
            ctrl.is_jump   = 1'b0;
            ctrl.is_system = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/imm_gen.sv
`timescale 1ns/1ns
`default_nettype none

module imm_gen import rv_decode_pkg::*; (
    decode_bus_if.decode    bus,
    output logic [xlen-1:0] imm
);

    logic [xlen-1:0] instr;
    logic            sign;
    logic            is_shift;

    assign instr    = bus.instruction;
    assign sign     = instr[xlen-1];
    assign is_shift = bus.funct3[1:0] == 2'b01;  // slli, srli, srai

    always_comb begin
        case (bus.opcode)
            jalr, load: begin
                imm = {{(xlen-12){sign}}, instr[31:20]};
            end
            op_imm: begin
                if (is_shift) begin
                    imm = {{(xlen-5){1'b0}}, instr[24:20]};  // shamt only
                end else begin
                    imm = {{(xlen-12){sign}}, instr[31:20]};
                end
            end
            store: begin
                imm = {{(xlen-12){sign}}, instr[31:25], instr[11:7]};
            end
            branch: begin
                imm = {{(xlen-13){sign}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            lui, auipc: begin
                imm = {instr[31:12], 12'b0};
            end
            jal: begin
                imm = {{(xlen-21){sign}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;  // fence, system, unknown
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/instr_capture.sv
`timescale 1ns/1ns
`default_nettype none

module instr_capture import rv_decode_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_valid,
    input  logic [xlen-1:0] instruction,
    decode_bus_if.capture   bus
);

    logic            valid_q;
    logic [xlen-1:0] instr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            instr_q <= instruction;  // holds last word across bubbles
        end
    end

    assign bus.valid       = valid_q;
    assign bus.instruction = instr_q;
    assign bus.opcode      = opcode_t'(instr_q[6:0]);
    assign bus.rd          = instr_q[11:7];
    assign bus.funct3      = instr_q[14:12];
    assign bus.rs1         = instr_q[19:15];
    assign bus.rs2         = instr_q[24:20];
    assign bus.funct7      = instr_q[31:25];

    // a strobed word must be fully known, the decode below trusts it
    assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid |-> !$isunknown(instruction))
        else $error("instruction has unknown bits while instr_valid is high");

endmodule

`default_nettype wire

//--- rtl/decode_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

interface decode_bus_if import rv_decode_pkg::*; ();

    logic            valid;
    logic [xlen-1:0] instruction;
    opcode_t         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    reg_addr_t       rd;
    reg_addr_t       rs1;
    reg_addr_t       rs2;

    modport capture (
        output valid, instruction, opcode, funct3, funct7, rd, rs1, rs2
    );

    modport decode (
        input valid, instruction, opcode, funct3, funct7, rd, rs1, rs2
    );

endinterface

`default_nettype wire

//--- rtl/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_addr_t;

    // major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        lui      = 7'b0110111,
        auipc    = 7'b0010111,
        jal      = 7'b1101111,
        jalr     = 7'b1100111,
        branch   = 7'b1100011,
        load     = 7'b0000011,
        store    = 7'b0100011,
        op_imm   = 7'b0010011,
        op       = 7'b0110011,
        misc_mem = 7'b0001111,  // fence
        system   = 7'b1110011   // ecall, ebreak
    } opcode_t;

    typedef enum logic [3:0] {
        add,  // zero code, the idle value
        sub,
        slt,
        sltu,
        and_op,
        or_op,
        xor_op,
        sll,
        srl,
        sra,
        pass_b  // lui
    } alu_op_t;

    typedef enum logic [2:0] {
        none,
        beq,
        bne,
        blt,
        bge,
        bltu,
        bgeu
    } branch_op_t;

    // same order as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        width_byte,
        width_half,
        width_word
    } mem_width_t;

    typedef enum logic [1:0] {
        alu,  // alu result
        mem,  // load data
        pc4   // link address of jal and jalr
    } wb_sel_t;

    localparam logic [xlen-1:0] ecall_word  = 32'h0000_0073;
    localparam logic [xlen-1:0] ebreak_word = 32'h0010_0073;

    typedef struct packed {
        alu_op_t    alu_op;
        logic       a_is_pc;
        logic       b_is_imm;
        reg_addr_t  rs1;
        logic       rs1_read;
        reg_addr_t  rs2;
        logic       rs2_read;
        reg_addr_t  rd;
        logic       rd_write;
        wb_sel_t    wb_sel;
        logic       mem_read;
        logic       mem_write;
        mem_width_t mem_width;
        logic       mem_unsigned;
        branch_op_t branch_op;
        logic       is_jump;
        logic       is_system;
        logic       illegal;
    } ctrl_t;

endpackage

`default_nettype wire
